/* hw/acq_csr_consts.svh */
`ifndef ACQ_CSR_CONSTS_SVH
`define ACQ_CSR_CONSTS_SVH

`default_nettype none

// --------------------------------------------------
// Register map, byte offsets
// --------------------------------------------------
`define ACQ_ADDR_W          5

`define ACQ_REG_CTRL_ID     5'h00   // Identity and initiator reset
`define ACQ_REG_START       5'h04   // Memory write start
`define ACQ_REG_QUEUE_ADDR  5'h08
`define ACQ_REG_DAC         5'h0C
`define ACQ_REG_CFG1_HI     5'h10   // Upper field of config word 1
`define ACQ_REG_CFG2        5'h14
`define ACQ_REG_PKT_COUNT   5'h18   // Packets per buffer
`define ACQ_REG_FRAME_LEN   5'h1C   // Lower field of config word 1

// --------------------------------------------------
// Reset values and identity codes
// --------------------------------------------------
`define ACQ_DAC_RST         32'h8080_8080
`define ACQ_CFG1_RST        32'h0002_1FFF
`define ACQ_CFG2_RST        32'h0002_0000
`define ACQ_PKT_COUNT_RST   32'd32768

`define ACQ_VERSION         8'h16
`define ACQ_FAMILY_DEF      8'h14
`define ACQ_IFACE_DEF       4'h2

`default_nettype wire

`endif

/* hw/axil_pkg.sv */
`default_nettype none

package axil_pkg;

    typedef logic [31:0] axil_data_t;
    typedef logic [31:0] axil_addr_t;
    typedef logic [3:0]  axil_strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    // Write side waits only for the B handshake
    typedef enum logic {
        W_IDLE,
        W_RESP
    } axil_wr_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,     // Bank is fetching the word
        R_DATA
    } axil_rd_state_t;

endpackage

`default_nettype wire

/* hw/acq_csr_pkg.sv */
`default_nettype none

package acq_csr_pkg;

    // --------------------------------------------------
    // Register words and indices
    // --------------------------------------------------
    typedef logic [31:0] csr_word_t;
    typedef logic [2:0]  reg_idx_t;     // One of eight word slots

    // --------------------------------------------------
    // Fields of config word 1
    // --------------------------------------------------
    typedef logic [18:0] cfg1_hi_t;     // Bits 31:13
    typedef logic [12:0] frame_len_t;   // Bits 12:0

    // --------------------------------------------------
    // Identity fields of CTRL_ID
    // --------------------------------------------------
    typedef logic [7:0]  family_id_t;   // FPGA family code
    typedef logic [3:0]  iface_id_t;    // Data path code

endpackage

`default_nettype wire

/* hw/axil_csr_slave.sv */
`include "acq_csr_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module axil_csr_slave (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // AXI4-Lite write address and data
    input  wire axil_pkg::axil_addr_t   s_awaddr_i,
    input  wire logic                   s_awvalid_i,
    output logic                        s_awready_o,
    input  wire axil_pkg::axil_data_t   s_wdata_i,
    input  wire axil_pkg::axil_strb_t   s_wstrb_i,
    input  wire logic                   s_wvalid_i,
    output logic                        s_wready_o,
    output axil_pkg::axil_resp_t        s_bresp_o,
    output logic                        s_bvalid_o,
    input  wire logic                   s_bready_i,

    // AXI4-Lite read
    input  wire axil_pkg::axil_addr_t   s_araddr_i,
    input  wire logic                   s_arvalid_i,
    output logic                        s_arready_o,
    output axil_pkg::axil_data_t        s_rdata_o,
    output axil_pkg::axil_resp_t        s_rresp_o,
    output logic                        s_rvalid_o,
    input  wire logic                   s_rready_i,

    // Register bank strobes
    output logic                        wr_en_o,
    output acq_csr_pkg::reg_idx_t       wr_idx_o,
    output acq_csr_pkg::csr_word_t      wr_data_o,
    output logic                        wr_hit_o,
    output logic                        rd_en_o,
    output acq_csr_pkg::reg_idx_t       rd_idx_o,
    output logic                        rd_hit_o,
    input  wire acq_csr_pkg::csr_word_t rd_data_i
);

    import axil_pkg::*;
    import acq_csr_pkg::*;

    localparam int ADDR_MSB = $bits(axil_addr_t) - 1;

    axil_wr_state_t wr_state_q;
    axil_rd_state_t rd_state_q;
    axil_resp_t     bresp_q;
    csr_word_t      rdata_q;
    logic           wr_hs;
    logic           rd_hs;
    logic           strb_full;

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    // AW and W are taken together, so either may come first
    assign wr_hs       = (wr_state_q == W_IDLE) && s_awvalid_i && s_wvalid_i;
    assign strb_full   = &s_wstrb_i;
    assign s_awready_o = wr_hs;
    assign s_wready_o  = wr_hs;

    assign wr_en_o   = wr_hs && strb_full;  // Partial strobe writes nothing
    assign wr_idx_o  = s_awaddr_i[`ACQ_ADDR_W-1:2];
    assign wr_hit_o  = ~|s_awaddr_i[ADDR_MSB:`ACQ_ADDR_W];
    assign wr_data_o = s_wdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state_q <= W_IDLE;
        end else begin
            case (wr_state_q)
                W_IDLE: begin
                    if (wr_hs) begin
                        wr_state_q <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (s_bready_i) begin
                        wr_state_q <= W_IDLE;
                    end
                end
                default: wr_state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp_q <= strb_full ? OKAY : SLVERR;
        end
    end

    assign s_bvalid_o = (wr_state_q == W_RESP);
    assign s_bresp_o  = bresp_q;

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    // Ready only when idle and an address is offered
    assign rd_hs       = (rd_state_q == R_IDLE) && s_arvalid_i;
    assign s_arready_o = rd_hs;

    assign rd_en_o  = rd_hs;
    assign rd_idx_o = s_araddr_i[`ACQ_ADDR_W-1:2];
    assign rd_hit_o = ~|s_araddr_i[ADDR_MSB:`ACQ_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state_q <= R_IDLE;
        end else begin
            case (rd_state_q)
                R_IDLE: begin
                    if (rd_hs) begin
                        rd_state_q <= R_WAIT;
                    end
                end
                R_WAIT: rd_state_q <= R_DATA;   // Bank output valid now
                R_DATA: begin
                    if (s_rready_i) begin
                        rd_state_q <= R_IDLE;
                    end
                end
                default: rd_state_q <= R_IDLE;
            endcase
        end
    end

    // Hold the word so rdata stays put under back-pressure
    always_ff @(posedge clk) begin
        if (rd_state_q == R_WAIT) begin
            rdata_q <= rd_data_i;
        end
    end

    assign s_rvalid_o = (rd_state_q == R_DATA);
    assign s_rdata_o  = rdata_q;
    assign s_rresp_o  = OKAY;

    // --------------------------------------------------
    // Protocol checks
    // --------------------------------------------------
    property p_hold_valid(valid, ready);
        @(posedge clk) disable iff (!rst_n)
            valid && !ready |=> valid;
    endproperty

    a_bvalid_hold: assert property (p_hold_valid(s_bvalid_o, s_bready_i));
    a_rvalid_hold: assert property (p_hold_valid(s_rvalid_o, s_rready_i));

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        s_rvalid_o && !s_rready_i |=> $stable(s_rdata_o));

endmodule

`default_nettype wire

/* hw/acq_csr_bank.sv */
`include "acq_csr_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module acq_csr_bank (
    input  wire logic                       clk,
    input  wire logic                       rst_n,

    // Strobes from the bus slave
    input  wire logic                       wr_en_i,
    input  wire acq_csr_pkg::reg_idx_t      wr_idx_i,
    input  wire acq_csr_pkg::csr_word_t     wr_data_i,
    input  wire logic                       wr_hit_i,
    input  wire logic                       rd_en_i,
    input  wire acq_csr_pkg::reg_idx_t      rd_idx_i,
    input  wire logic                       rd_hit_i,
    output acq_csr_pkg::csr_word_t          rd_data_o,

    input  wire acq_csr_pkg::family_id_t    family_i,
    input  wire acq_csr_pkg::iface_id_t     iface_i,
    input  wire acq_csr_pkg::csr_word_t     cur_addr_i,  // Live DMA write address

    // Register outputs
    output logic                            init_rst_o,
    output logic                            mwr_start_o,
    output acq_csr_pkg::csr_word_t          queue_addr_o,
    output logic                            queue_addr_wr_o,
    output acq_csr_pkg::csr_word_t          dac_data_o,
    output acq_csr_pkg::csr_word_t          cfg1_o,
    output acq_csr_pkg::csr_word_t          cfg2_o,
    output acq_csr_pkg::csr_word_t          pkt_count_o
);

    import acq_csr_pkg::*;

    // --------------------------------------------------
    // Word indices from the byte offsets
    // --------------------------------------------------
    localparam reg_idx_t IDX_CTRL_ID    = reg_idx_t'(`ACQ_REG_CTRL_ID >> 2);
    localparam reg_idx_t IDX_START      = reg_idx_t'(`ACQ_REG_START >> 2);
    localparam reg_idx_t IDX_QUEUE_ADDR = reg_idx_t'(`ACQ_REG_QUEUE_ADDR >> 2);
    localparam reg_idx_t IDX_DAC        = reg_idx_t'(`ACQ_REG_DAC >> 2);
    localparam reg_idx_t IDX_CFG1_HI    = reg_idx_t'(`ACQ_REG_CFG1_HI >> 2);
    localparam reg_idx_t IDX_CFG2       = reg_idx_t'(`ACQ_REG_CFG2 >> 2);
    localparam reg_idx_t IDX_PKT_COUNT  = reg_idx_t'(`ACQ_REG_PKT_COUNT >> 2);
    localparam reg_idx_t IDX_FRAME_LEN  = reg_idx_t'(`ACQ_REG_FRAME_LEN >> 2);

    localparam csr_word_t  CFG1_RST = `ACQ_CFG1_RST;
    localparam logic [7:0] VERSION  = `ACQ_VERSION;

    cfg1_hi_t   cfg1_hi_q;
    frame_len_t frame_len_q;
    csr_word_t  id_word;
    logic       wr_sel;

    assign wr_sel = wr_en_i && wr_hit_i;     // Unmapped writes drop here
    assign cfg1_o = {cfg1_hi_q, frame_len_q};

    // Family, 4 spare, iface, version, 7 spare, reset bit
    assign id_word = {family_i, 4'b0, iface_i, VERSION, 7'b0, init_rst_o};

    // --------------------------------------------------
    // Register writes
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o      <= 1'b0;
            mwr_start_o     <= 1'b0;
            queue_addr_o    <= '0;
            queue_addr_wr_o <= 1'b0;
            dac_data_o      <= `ACQ_DAC_RST;
            cfg1_hi_q       <= CFG1_RST[31:13];
            frame_len_q     <= CFG1_RST[12:0];
            cfg2_o          <= `ACQ_CFG2_RST;
            pkt_count_o     <= `ACQ_PKT_COUNT_RST;
        end else begin
            queue_addr_wr_o <= 1'b0;             // Single cycle strobe
            if (wr_sel) begin
                case (wr_idx_i)
                    IDX_CTRL_ID: init_rst_o <= wr_data_i[0];
                    IDX_START:   mwr_start_o <= wr_data_i[0];
                    IDX_QUEUE_ADDR: begin
                        queue_addr_o    <= wr_data_i;
                        queue_addr_wr_o <= 1'b1; // Tells DMA a new buffer is queued
                    end
                    IDX_DAC:       dac_data_o  <= wr_data_i;
                    IDX_CFG1_HI:   cfg1_hi_q   <= wr_data_i[18:0];
                    IDX_CFG2:      cfg2_o      <= wr_data_i;
                    IDX_PKT_COUNT: pkt_count_o <= wr_data_i;
                    IDX_FRAME_LEN: frame_len_q <= wr_data_i[12:0];
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Readback, one cycle after rd_en
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            if (!rd_hit_i) begin
                rd_data_o <= '0;
            end else begin
                case (rd_idx_i)
                    IDX_CTRL_ID:    rd_data_o <= id_word;
                    IDX_START:      rd_data_o <= '0;          // Write only
                    IDX_QUEUE_ADDR: rd_data_o <= cur_addr_i;
                    IDX_DAC:        rd_data_o <= dac_data_o;
                    IDX_CFG1_HI:    rd_data_o <= csr_word_t'(cfg1_hi_q);
                    IDX_CFG2:       rd_data_o <= cfg2_o;
                    IDX_PKT_COUNT:  rd_data_o <= pkt_count_o;
                    IDX_FRAME_LEN:  rd_data_o <= csr_word_t'(frame_len_q);
                    default:        rd_data_o <= '0;
                endcase
            end
        end
    end

    // Slave needs at least two cycles between write handshakes
    a_qwr_single: assert property (@(posedge clk) disable iff (!rst_n)
        queue_addr_wr_o |=> !queue_addr_wr_o);

endmodule

`default_nettype wire

/* hw/acq_ctrl_top.sv */
`include "acq_csr_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module acq_ctrl_top #(
    parameter acq_csr_pkg::family_id_t FAMILY_ID = `ACQ_FAMILY_DEF,
    parameter acq_csr_pkg::iface_id_t  IFACE_ID  = `ACQ_IFACE_DEF
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // Host port
    input  wire axil_pkg::axil_addr_t   s_awaddr_i,
    input  wire logic                   s_awvalid_i,
    output logic                        s_awready_o,
    input  wire axil_pkg::axil_data_t   s_wdata_i,
    input  wire axil_pkg::axil_strb_t   s_wstrb_i,
    input  wire logic                   s_wvalid_i,
    output logic                        s_wready_o,
    output axil_pkg::axil_resp_t        s_bresp_o,
    output logic                        s_bvalid_o,
    input  wire logic                   s_bready_i,
    input  wire axil_pkg::axil_addr_t   s_araddr_i,
    input  wire logic                   s_arvalid_i,
    output logic                        s_arready_o,
    output axil_pkg::axil_data_t        s_rdata_o,
    output axil_pkg::axil_resp_t        s_rresp_o,
    output logic                        s_rvalid_o,
    input  wire logic                   s_rready_i,

    input  wire acq_csr_pkg::csr_word_t cur_addr_i,

    // Control to the DMA engine and front end
    output logic                        init_rst_o,
    output logic                        mwr_start_o,
    output acq_csr_pkg::csr_word_t      queue_addr_o,
    output logic                        queue_addr_wr_o,
    output acq_csr_pkg::csr_word_t      dac_data_o,
    output acq_csr_pkg::csr_word_t      cfg1_o,
    output acq_csr_pkg::csr_word_t      cfg2_o,
    output acq_csr_pkg::csr_word_t      pkt_count_o
);

    import acq_csr_pkg::*;

    // --------------------------------------------------
    // Slave to bank strobes
    // --------------------------------------------------
    logic      wr_en;
    reg_idx_t  wr_idx;
    csr_word_t wr_data;
    logic      wr_hit;
    logic      rd_en;
    reg_idx_t  rd_idx;
    logic      rd_hit;
    csr_word_t rd_data;

    axil_csr_slave i_axil_csr_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .wr_en_o     (wr_en),
        .wr_idx_o    (wr_idx),
        .wr_data_o   (wr_data),
        .wr_hit_o    (wr_hit),
        .rd_en_o     (rd_en),
        .rd_idx_o    (rd_idx),
        .rd_hit_o    (rd_hit),
        .rd_data_i   (rd_data)
    );

    acq_csr_bank i_acq_csr_bank (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_en_i         (wr_en),
        .wr_idx_i        (wr_idx),
        .wr_data_i       (wr_data),
        .wr_hit_i        (wr_hit),
        .rd_en_i         (rd_en),
        .rd_idx_i        (rd_idx),
        .rd_hit_i        (rd_hit),
        .rd_data_o       (rd_data),
        .family_i        (FAMILY_ID),     // Identity fixed at build time
        .iface_i         (IFACE_ID),
        .cur_addr_i      (cur_addr_i),
        .init_rst_o      (init_rst_o),
        .mwr_start_o     (mwr_start_o),
        .queue_addr_o    (queue_addr_o),
        .queue_addr_wr_o (queue_addr_wr_o),
        .dac_data_o      (dac_data_o),
        .cfg1_o          (cfg1_o),
        .cfg2_o          (cfg2_o),
        .pkt_count_o     (pkt_count_o)
    );

endmodule

`default_nettype wire

/* test/tb_acq_ctrl.sv */
`include "acq_csr_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_acq_ctrl;

    import axil_pkg::*;
    import acq_csr_pkg::*;

    localparam int TIMEOUT_CYC = 50;

    logic       clk;
    logic       rst_n;
    axil_addr_t s_awaddr_i;
    logic       s_awvalid_i;
    logic       s_awready_o;
    axil_data_t s_wdata_i;
    axil_strb_t s_wstrb_i;
    logic       s_wvalid_i;
    logic       s_wready_o;
    axil_resp_t s_bresp_o;
    logic       s_bvalid_o;
    logic       s_bready_i;
    axil_addr_t s_araddr_i;
    logic       s_arvalid_i;
    logic       s_arready_o;
    axil_data_t s_rdata_o;
    axil_resp_t s_rresp_o;
    logic       s_rvalid_o;
    logic       s_rready_i;
    csr_word_t  cur_addr_i;
    logic       init_rst_o;
    logic       mwr_start_o;
    csr_word_t  queue_addr_o;
    logic       queue_addr_wr_o;
    csr_word_t  dac_data_o;
    csr_word_t  cfg1_o;
    csr_word_t  cfg2_o;
    csr_word_t  pkt_count_o;

    int qwr_count;      // Cycles with the queue strobe high
    int rd_lat;         // AR handshake to first rvalid, in cycles

    acq_ctrl_top i_acq_ctrl_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_awaddr_i      (s_awaddr_i),
        .s_awvalid_i     (s_awvalid_i),
        .s_awready_o     (s_awready_o),
        .s_wdata_i       (s_wdata_i),
        .s_wstrb_i       (s_wstrb_i),
        .s_wvalid_i      (s_wvalid_i),
        .s_wready_o      (s_wready_o),
        .s_bresp_o       (s_bresp_o),
        .s_bvalid_o      (s_bvalid_o),
        .s_bready_i      (s_bready_i),
        .s_araddr_i      (s_araddr_i),
        .s_arvalid_i     (s_arvalid_i),
        .s_arready_o     (s_arready_o),
        .s_rdata_o       (s_rdata_o),
        .s_rresp_o       (s_rresp_o),
        .s_rvalid_o      (s_rvalid_o),
        .s_rready_i      (s_rready_i),
        .cur_addr_i      (cur_addr_i),
        .init_rst_o      (init_rst_o),
        .mwr_start_o     (mwr_start_o),
        .queue_addr_o    (queue_addr_o),
        .queue_addr_wr_o (queue_addr_wr_o),
        .dac_data_o      (dac_data_o),
        .cfg1_o          (cfg1_o),
        .cfg2_o          (cfg2_o),
        .pkt_count_o     (pkt_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (queue_addr_wr_o) begin
            qwr_count = qwr_count + 1;
        end
    end

    // --------------------------------------------------
    // Checking and bus tasks
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Done: errors found");
        $fatal(1, "Wait loop timed out");
    endtask

    // Identity word as the register map defines it
    function automatic logic [31:0] expected_id(input logic init);
        return {`ACQ_FAMILY_DEF, 4'h0, `ACQ_IFACE_DEF, `ACQ_VERSION, 7'h0, init};
    endfunction

    task automatic wait_write_accept();
        int   cnt;
        logic hs;
        cnt = 0;
        hs  = 1'b0;
        while (!hs) begin
            #1;
            hs = s_awready_o && s_wready_o;  // Taken at the next rising edge
            @(negedge clk);
            cnt++;
            if (!hs && cnt > TIMEOUT_CYC) begin
                timeout_fail("AW and W handshake");
            end
        end
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
    endtask

    task automatic wait_bresp(output axil_resp_t resp);
        int   cnt;
        logic seen;
        cnt  = 0;
        seen = 1'b0;
        while (!seen) begin
            #1;
            seen = s_bvalid_o;
            resp = s_bresp_o;
            @(negedge clk);
            cnt++;
            if (!seen && cnt > TIMEOUT_CYC) begin
                timeout_fail("write response");
            end
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input axil_resp_t exp_resp);
        axil_resp_t resp;
        @(negedge clk);
        s_awaddr_i  = addr;
        s_awvalid_i = 1'b1;
        s_wdata_i   = data;
        s_wstrb_i   = strb;
        s_wvalid_i  = 1'b1;
        wait_write_accept();
        wait_bresp(resp);
        check_value("bresp", resp, exp_resp);
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        int   cnt;
        logic hs;
        logic seen;
        @(negedge clk);
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        cnt = 0;
        hs  = 1'b0;
        while (!hs) begin
            #1;
            hs = s_arready_o;
            @(negedge clk);
            cnt++;
            if (!hs && cnt > TIMEOUT_CYC) begin
                timeout_fail("read address handshake");
            end
        end
        s_arvalid_i = 1'b0;
        rd_lat = 0;
        seen   = 1'b0;
        while (!seen) begin
            rd_lat++;
            #1;
            seen = s_rvalid_o;
            data = s_rdata_o;
            resp = s_rresp_o;
            @(negedge clk);
            if (!seen && rd_lat > TIMEOUT_CYC) begin
                timeout_fail("read data");
            end
        end
    endtask

    task automatic read_expect(input axil_addr_t addr, input csr_word_t exp,
                               input string name);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check_value(name, data, exp);
        check_value({name, " rresp"}, resp, OKAY);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_values();
        check_value("s_awready_o", s_awready_o, 1'b0);
        check_value("s_wready_o", s_wready_o, 1'b0);
        check_value("s_arready_o", s_arready_o, 1'b0);
        check_value("s_bvalid_o", s_bvalid_o, 1'b0);
        check_value("s_rvalid_o", s_rvalid_o, 1'b0);
        check_value("init_rst_o", init_rst_o, 1'b0);
        check_value("mwr_start_o", mwr_start_o, 1'b0);
        check_value("queue_addr_wr_o", queue_addr_wr_o, 1'b0);
        check_value("queue_addr_o", queue_addr_o, 32'h0);
        check_value("dac_data_o", dac_data_o, `ACQ_DAC_RST);
        check_value("cfg1_o", cfg1_o, `ACQ_CFG1_RST);
        check_value("cfg2_o", cfg2_o, `ACQ_CFG2_RST);
        check_value("pkt_count_o", pkt_count_o, `ACQ_PKT_COUNT_RST);
        read_expect(`ACQ_REG_CTRL_ID, expected_id(1'b0), "CTRL_ID");
        read_expect(`ACQ_REG_START, 32'h0, "START");
        read_expect(`ACQ_REG_QUEUE_ADDR, 32'h0, "QUEUE_ADDR");
        read_expect(`ACQ_REG_DAC, `ACQ_DAC_RST, "DAC");
        read_expect(`ACQ_REG_CFG1_HI, `ACQ_CFG1_RST >> 13, "CFG1_HI");
        read_expect(`ACQ_REG_CFG2, `ACQ_CFG2_RST, "CFG2");
        read_expect(`ACQ_REG_PKT_COUNT, `ACQ_PKT_COUNT_RST, "PKT_COUNT");
        read_expect(`ACQ_REG_FRAME_LEN, `ACQ_CFG1_RST & 32'h1FFF, "FRAME_LEN");
    endtask

    task automatic test_rw_words();
        csr_word_t d_dac;
        csr_word_t d_cfg2;
        csr_word_t d_pkt;
        d_dac  = $urandom;
        d_cfg2 = $urandom;
        d_pkt  = $urandom;
        axil_write(`ACQ_REG_DAC, d_dac, 4'hF, OKAY);
        axil_write(`ACQ_REG_CFG2, d_cfg2, 4'hF, OKAY);
        axil_write(`ACQ_REG_PKT_COUNT, d_pkt, 4'hF, OKAY);
        check_value("dac_data_o", dac_data_o, d_dac);
        check_value("cfg2_o", cfg2_o, d_cfg2);
        check_value("pkt_count_o", pkt_count_o, d_pkt);
        read_expect(`ACQ_REG_DAC, d_dac, "DAC");
        read_expect(`ACQ_REG_CFG2, d_cfg2, "CFG2");
        read_expect(`ACQ_REG_PKT_COUNT, d_pkt, "PKT_COUNT");

        axil_write(`ACQ_REG_START, 32'h1, 4'hF, OKAY);
        check_value("mwr_start_o", mwr_start_o, 1'b1);
        read_expect(`ACQ_REG_START, 32'h0, "START");    // Write only
        axil_write(`ACQ_REG_CTRL_ID, 32'h1, 4'hF, OKAY);
        check_value("init_rst_o", init_rst_o, 1'b1);
        read_expect(`ACQ_REG_CTRL_ID, expected_id(1'b1), "CTRL_ID");
        axil_write(`ACQ_REG_CTRL_ID, 32'h0, 4'hF, OKAY);
        axil_write(`ACQ_REG_START, 32'h0, 4'hF, OKAY);
        check_value("init_rst_o", init_rst_o, 1'b0);
        check_value("mwr_start_o", mwr_start_o, 1'b0);
    endtask

    task automatic test_split_cfg();
        csr_word_t d_hi;
        csr_word_t d_lo;
        d_hi = $urandom;
        d_lo = $urandom;
        axil_write(`ACQ_REG_CFG1_HI, d_hi, 4'hF, OKAY);
        axil_write(`ACQ_REG_FRAME_LEN, d_lo, 4'hF, OKAY);
        check_value("cfg1_o", cfg1_o, {d_hi[18:0], d_lo[12:0]});
        read_expect(`ACQ_REG_CFG1_HI, {13'h0, d_hi[18:0]}, "CFG1_HI");
        read_expect(`ACQ_REG_FRAME_LEN, {19'h0, d_lo[12:0]}, "FRAME_LEN");
    endtask

    task automatic test_queue_addr();
        csr_word_t qa;
        csr_word_t cur;
        qa  = $urandom;
        cur = $urandom;
        qwr_count = 0;
        axil_write(`ACQ_REG_QUEUE_ADDR, qa, 4'hF, OKAY);
        repeat (3) @(negedge clk);
        check_value("queue_addr_o", queue_addr_o, qa);
        check_value("queue_addr_wr_o pulse count", qwr_count, 1);
        cur_addr_i = cur;               // Readback follows the live address
        read_expect(`ACQ_REG_QUEUE_ADDR, cur, "QUEUE_ADDR");
    endtask

    task automatic test_errors();
        csr_word_t dac_old;
        dac_old = dac_data_o;
        axil_write(`ACQ_REG_DAC, ~dac_old, 4'b0111, SLVERR);
        check_value("dac_data_o", dac_data_o, dac_old);
        read_expect(`ACQ_REG_DAC, dac_old, "DAC");
        // Offset 0x2C would alias DAC without the upper bit check
        axil_write(32'h20 | `ACQ_REG_DAC, ~dac_old, 4'hF, OKAY);
        check_value("dac_data_o", dac_data_o, dac_old);
        read_expect(32'h0000_0020, 32'h0, "unmapped 0x20");
        read_expect(32'h8000_000C, 32'h0, "unmapped 0x8000000C");
    endtask

    task automatic test_order_backpressure();
        csr_word_t  d1;
        csr_word_t  d2;
        csr_word_t  d3;
        csr_word_t  pkt_old;
        axil_data_t rdata;
        axil_resp_t resp;
        d1 = $urandom;
        d2 = $urandom;
        d3 = $urandom;

        // W ahead of AW
        @(negedge clk);
        s_wdata_i  = d1;
        s_wstrb_i  = 4'hF;
        s_wvalid_i = 1'b1;
        repeat (3) begin
            #1;
            check_value("s_wready_o", s_wready_o, 1'b0);
            @(negedge clk);
        end
        s_awaddr_i  = `ACQ_REG_DAC;
        s_awvalid_i = 1'b1;
        wait_write_accept();
        wait_bresp(resp);
        check_value("bresp", resp, OKAY);
        check_value("dac_data_o", dac_data_o, d1);

        // Hold off B, a second write must stall behind it
        pkt_old    = pkt_count_o;
        s_bready_i = 1'b0;
        s_awaddr_i  = `ACQ_REG_CFG2;
        s_wdata_i   = d2;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        wait_write_accept();
        s_awaddr_i  = `ACQ_REG_PKT_COUNT;
        s_wdata_i   = d3;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        repeat (5) begin
            #1;
            check_value("s_bvalid_o", s_bvalid_o, 1'b1);
            check_value("s_awready_o", s_awready_o, 1'b0);
            @(negedge clk);
        end
        check_value("pkt_count_o", pkt_count_o, pkt_old);
        s_bready_i = 1'b1;
        wait_bresp(resp);
        check_value("bresp", resp, OKAY);
        wait_write_accept();
        wait_bresp(resp);
        check_value("bresp", resp, OKAY);
        check_value("cfg2_o", cfg2_o, d2);
        check_value("pkt_count_o", pkt_count_o, d3);

        axil_read(`ACQ_REG_DAC, rdata, resp);
        check_value("read latency", rd_lat, 2);
        check_value("DAC", rdata, d1);
    endtask

    initial begin
        void'($urandom(28));
        rst_n       = 1'b0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b1;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b1;
        cur_addr_i  = '0;
        qwr_count   = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_reset_values();
        test_rw_words();
        test_split_cfg();
        test_queue_addr();
        test_errors();
        test_order_backpressure();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/axil_pkg.sv
hw/acq_csr_pkg.sv
hw/axil_csr_slave.sv
hw/acq_csr_bank.sv
hw/acq_ctrl_top.sv
test/tb_acq_ctrl.sv

/* Bender.yml */
package:
  name: acq_ctrl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/axil_pkg.sv
      - hw/acq_csr_pkg.sv
      - hw/axil_csr_slave.sv
      - hw/acq_csr_bank.sv
      - hw/acq_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_acq_ctrl.sv
